// File: Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/cpu_control.sv
      - source/cpu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_memory.sv
      - test/tb_cpu.sv

// File: source/alu.sv
`include "cpu_defs.svh"

module alu (
    input  cpu_pkg::instr_u       instr,
    input  logic [`CPU_XLEN-1:0]  a_data,
    input  logic [`CPU_XLEN-1:0]  b_data,
    input  logic                  a_flag,
    input  logic [`CPU_XLEN-1:0]  pc,
    output logic [`CPU_XLEN-1:0]  result,
    output logic                  result_flag,
    output logic [`CPU_XLEN-1:0]  next_pc,
    output logic [`CPU_XLEN-1:0]  mem_addr_calc
);
    import cpu_pkg::*;

    localparam int HALF    = `CPU_XLEN / 2;
    localparam int SHAMT_W = $clog2(`CPU_XLEN);

    logic [`CPU_XLEN-1:0] imm_sext;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic [`CPU_XLEN-1:0] branch_target;
    logic [`CPU_XLEN-1:0] jump_target;
    logic                 is_compare;

    assign imm_sext      = {{HALF{instr.r.imm[HALF-1]}}, instr.r.imm};
    assign pc_plus4      = pc + 4;
    assign branch_target = pc_plus4 + (imm_sext << 2);
    assign jump_target   = {{(`CPU_OPCODE_W-2){1'b0}}, instr.j.target, 2'b00};

    // base register plus signed offset for LOAD and STORE
    assign mem_addr_calc = a_data + imm_sext;

    always_comb
    begin
        result     = '0;
        is_compare = 1'b0;
        case (instr.r.opcode)
            ADD:   result = a_data + b_data;
            SUB:   result = a_data - b_data;
            AND:   result = a_data & b_data;
            OR:    result = a_data | b_data;
            XOR:   result = a_data ^ b_data;
            SHL:   result = a_data << b_data[SHAMT_W-1:0];
            SHR:   result = a_data >> b_data[SHAMT_W-1:0];
            CMPEQ:
            begin
                result     = {{(`CPU_XLEN-1){1'b0}}, a_data == b_data};
                is_compare = 1'b1;
            end
            CMPLT:
            begin
                result     = {{(`CPU_XLEN-1){1'b0}}, a_data < b_data};
                is_compare = 1'b1;
            end
            LDI:
            begin
                // a_data holds rd here so the low half survives a high write
                if (instr.r.highlow)
                    result = {instr.r.imm, a_data[HALF-1:0]};
                else
                    result = {{HALF{1'b0}}, instr.r.imm};
            end
            default: result = '0;
        endcase
    end

    // compares copy their outcome and everything else flags a zero result
    assign result_flag = is_compare ? result[0] : (result == '0);

    always_comb
    begin
        case (instr.r.opcode)
            BRF:     next_pc = a_flag ? branch_target : pc_plus4;
            JMP:     next_pc = jump_target;
            default: next_pc = pc_plus4;
        endcase
    end

endmodule

// File: source/cpu_control.sv
`include "cpu_defs.svh"

module cpu_control (
    input  logic                  clock,
    input  logic                  rst_n,
    output cpu_pkg::instr_u       instr,
    output logic [`CPU_XLEN-1:0]  pc,
    output logic [`CPU_IDX_W-1:0] ra_index,
    output logic [`CPU_IDX_W-1:0] rb_index,
    input  logic [`CPU_XLEN-1:0]  alu_result,
    input  logic                  alu_flag,
    input  logic [`CPU_XLEN-1:0]  alu_next_pc,
    input  logic [`CPU_XLEN-1:0]  alu_mem_addr,
    input  logic [`CPU_XLEN-1:0]  rb_data,
    output logic                  wr_en,
    output logic [`CPU_IDX_W-1:0] wr_index,
    output logic [`CPU_XLEN-1:0]  wr_data,
    output logic                  wr_flag,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output logic [`CPU_XLEN-1:0]  mem_addr,
    output logic                  mem_write,
    output logic [`CPU_XLEN-1:0]  mem_wdata,
    input  logic                  mem_rsp_valid,
    input  logic [`CPU_XLEN-1:0]  mem_rdata,
    output logic                  halted
);
    import cpu_pkg::*;

    ctrl_state_e state;
    opcode_e     op;
    logic        exec_writes;
    logic        req_accept;
    logic        load_done;

    assign op         = instr.r.opcode;
    assign req_accept = mem_req_valid && mem_req_ready;
    assign load_done  = (state == MEM_WAIT) && mem_rsp_valid && (op == LOAD);
    assign halted     = (state == HALTED);

    // instructions that write rd during EXECUTE
    always_comb
    begin
        case (op)
            ADD, SUB, AND, OR, XOR, SHL, SHR, CMPEQ, CMPLT, LDI: exec_writes = 1'b1;
            default: exec_writes = 1'b0;
        endcase
    end

    // LDI reads rd on port a so the ALU can keep the untouched half
    assign ra_index = (op == LDI) ? instr.r.rd : instr.r.ra;
    assign rb_index = instr.r.rb;

    assign wr_en    = ((state == EXECUTE) && exec_writes) || load_done;
    assign wr_index = instr.r.rd;
    assign wr_data  = (state == MEM_WAIT) ? mem_rdata : alu_result;
    assign wr_flag  = (state == MEM_WAIT) ? (mem_rdata == '0) : alu_flag;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state         <= FETCH;
            pc            <= `CPU_RESET_PC;
            instr         <= '0;
            mem_req_valid <= 1'b0;
            mem_write     <= 1'b0;
        end
        else
        begin
            case (state)
                FETCH:
                begin
                    mem_req_valid <= 1'b1;
                    mem_write     <= 1'b0;
                    state         <= WAIT_INSTR;
                end
                WAIT_INSTR:
                begin
                    // response only counts once the request has gone out
                    if (req_accept)
                        mem_req_valid <= 1'b0;
                    else if (!mem_req_valid && mem_rsp_valid)
                    begin
                        instr <= mem_rdata;
                        state <= EXECUTE;
                    end
                end
                EXECUTE:
                begin
                    pc <= alu_next_pc;
                    case (op)
                        LOAD, STORE:
                        begin
                            mem_req_valid <= 1'b1;
                            mem_write     <= (op == STORE);
                            state         <= MEM_REQ;
                        end
                        HALT:    state <= HALTED;
                        default: state <= FETCH;
                    endcase
                end
                MEM_REQ:
                begin
                    if (req_accept)
                    begin
                        mem_req_valid <= 1'b0;
                        state         <= MEM_WAIT;
                    end
                end
                MEM_WAIT:
                begin
                    if (mem_rsp_valid)
                        state <= FETCH;
                end
                HALTED:  state <= HALTED;
                default: state <= FETCH;
            endcase
        end
    end

    // request payload is loaded on the edge that raises valid and held after
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_addr  <= '0;
            mem_wdata <= '0;
        end
        else if (state == FETCH)
            mem_addr <= pc;
        else if (state == EXECUTE)
        begin
            mem_addr  <= alu_mem_addr;
            mem_wdata <= rb_data;
        end
    end

endmodule

// File: source/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define CPU_XLEN 32

// number of registers and flags
`define CPU_NREGS 8

// register index width
`define CPU_IDX_W $clog2(`CPU_NREGS)

// opcode field in the low bits of every instruction
`define CPU_OPCODE_W 6

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: source/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        NOP   = 6'd0,
        ADD   = 6'd1,
        SUB   = 6'd2,
        AND   = 6'd3,
        OR    = 6'd4,
        XOR   = 6'd5,
        SHL   = 6'd6,
        SHR   = 6'd7,
        CMPEQ = 6'd8,
        CMPLT = 6'd9,
        LDI   = 6'd10,
        LOAD  = 6'd11,
        STORE = 6'd12,
        BRF   = 6'd13,
        JMP   = 6'd14,
        HALT  = 6'd15
    } opcode_e;

    // register form for everything except JMP
    typedef struct packed {
        logic [`CPU_XLEN/2-1:0]  imm;
        logic                    highlow;
        logic [`CPU_IDX_W-1:0]   rd;
        logic [`CPU_IDX_W-1:0]   rb;
        logic [`CPU_IDX_W-1:0]   ra;
        opcode_e                 opcode;
    } reg_form_s;

    // word target occupies everything above the opcode
    typedef struct packed {
        logic [`CPU_XLEN-`CPU_OPCODE_W-1:0] target;
        opcode_e                            opcode;
    } jump_form_s;

    typedef union packed {
        reg_form_s  r;
        jump_form_s j;
    } instr_u;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_INSTR,
        EXECUTE,
        MEM_REQ,
        MEM_WAIT,
        HALTED
    } ctrl_state_e;

endpackage

// File: source/cpu_top.sv
`include "cpu_defs.svh"

module cpu_top (
    input  logic                 clock,
    input  logic                 rst_n,
    output logic                 mem_req_valid,
    input  logic                 mem_req_ready,
    output logic [`CPU_XLEN-1:0] mem_addr,
    output logic                 mem_write,
    output logic [`CPU_XLEN-1:0] mem_wdata,
    input  logic                 mem_rsp_valid,
    input  logic [`CPU_XLEN-1:0] mem_rdata,
    output logic                 halted
);
    import cpu_pkg::*;

    instr_u                instr;
    logic [`CPU_XLEN-1:0]  pc;
    logic [`CPU_IDX_W-1:0] ra_index;
    logic [`CPU_IDX_W-1:0] rb_index;
    logic [`CPU_XLEN-1:0]  ra_data;
    logic [`CPU_XLEN-1:0]  rb_data;
    logic                  ra_flag;
    logic                  wr_en;
    logic [`CPU_IDX_W-1:0] wr_index;
    logic [`CPU_XLEN-1:0]  wr_data;
    logic                  wr_flag;
    logic [`CPU_XLEN-1:0]  alu_result;
    logic                  alu_flag;
    logic [`CPU_XLEN-1:0]  alu_next_pc;
    logic [`CPU_XLEN-1:0]  alu_mem_addr;

    cpu_control u_control (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr         (instr),
        .pc            (pc),
        .ra_index      (ra_index),
        .rb_index      (rb_index),
        .alu_result    (alu_result),
        .alu_flag      (alu_flag),
        .alu_next_pc   (alu_next_pc),
        .alu_mem_addr  (alu_mem_addr),
        .rb_data       (rb_data),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_data       (wr_data),
        .wr_flag       (wr_flag),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_addr      (mem_addr),
        .mem_write     (mem_write),
        .mem_wdata     (mem_wdata),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .halted        (halted)
    );

    reg_file u_regs (
        .clock    (clock),
        .rst_n    (rst_n),
        .ra_index (ra_index),
        .rb_index (rb_index),
        .ra_data  (ra_data),
        .rb_data  (rb_data),
        .ra_flag  (ra_flag),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_flag  (wr_flag)
    );

    alu u_alu (
        .instr         (instr),
        .a_data        (ra_data),
        .b_data        (rb_data),
        .a_flag        (ra_flag),
        .pc            (pc),
        .result        (alu_result),
        .result_flag   (alu_flag),
        .next_pc       (alu_next_pc),
        .mem_addr_calc (alu_mem_addr)
    );

endmodule

// File: source/reg_file.sv
`include "cpu_defs.svh"

module reg_file (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [`CPU_IDX_W-1:0] ra_index,
    input  logic [`CPU_IDX_W-1:0] rb_index,
    output logic [`CPU_XLEN-1:0]  ra_data,
    output logic [`CPU_XLEN-1:0]  rb_data,
    output logic                  ra_flag,
    input  logic                  wr_en,
    input  logic [`CPU_IDX_W-1:0] wr_index,
    input  logic [`CPU_XLEN-1:0]  wr_data,
    input  logic                  wr_flag
);

    logic [`CPU_XLEN-1:0]  regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0] flags;

    // register and its flag always move together
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_index]  <= wr_data;
            flags[wr_index] <= wr_flag;
        end
    end

    // combinational reads
    assign ra_data = regs[ra_index];
    assign rb_data = regs[rb_index];
    assign ra_flag = flags[ra_index];

endmodule

// File: src.f
+incdir+source
source/cpu_pkg.sv
source/reg_file.sv
source/alu.sv
source/cpu_control.sv
source/cpu_top.sv
test/tb_memory.sv
test/tb_cpu.sv

// File: test/tb_cpu.sv
`include "cpu_defs.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESULT_BASE    = 32'h300;

    logic                 clock;
    logic                 rst_n;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    logic [`CPU_XLEN-1:0] mem_addr;
    logic                 mem_write;
    logic [`CPU_XLEN-1:0] mem_wdata;
    logic                 mem_rsp_valid;
    logic [`CPU_XLEN-1:0] mem_rdata;
    logic                 halted;

    int mismatch_count;
    int fault_count;
    int cycles;

    // architectural model
    logic [`CPU_XLEN-1:0]  m_pc;
    logic [`CPU_XLEN-1:0]  m_regs [`CPU_NREGS];
    logic [`CPU_NREGS-1:0] m_flags;
    logic [`CPU_XLEN-1:0]  m_mem [256];

    // request held from a stalled edge
    logic                 held;
    logic [`CPU_XLEN-1:0] h_addr;
    logic                 h_write;
    logic [`CPU_XLEN-1:0] h_wdata;

    cpu_top DUT (
        .clock         (clock),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_addr      (mem_addr),
        .mem_write     (mem_write),
        .mem_wdata     (mem_wdata),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rdata     (mem_rdata),
        .halted        (halted)
    );

    tb_memory memory (
        .clock     (clock),
        .rst_n     (rst_n),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .addr      (mem_addr),
        .write     (mem_write),
        .wdata     (mem_wdata),
        .rsp_valid (mem_rsp_valid),
        .rdata     (mem_rdata)
    );

    always #50 clock = ~clock;

    task automatic report_fault(input string msg);
        $display("error: %s", msg);
        fault_count++;
    endtask

    task automatic check_addr(input string name, input logic [`CPU_XLEN-1:0] exp,
                              input logic [`CPU_XLEN-1:0] act);
        if (act !== exp)
        begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_data(input string name, input logic [`CPU_XLEN-1:0] exp,
                              input logic [`CPU_XLEN-1:0] act);
        if (act !== exp)
        begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_instr(input string name, input instr_u exp, input instr_u act);
        if (act !== exp)
        begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    function automatic instr_u enc_r(input opcode_e op, input int rd, input int ra,
                                     input int rb, input bit hl, input int imm);
        instr_u w;
        w.r.opcode  = op;
        w.r.rd      = rd[2:0];
        w.r.ra      = ra[2:0];
        w.r.rb      = rb[2:0];
        w.r.highlow = hl;
        w.r.imm     = imm[15:0];
        return w;
    endfunction

    function automatic instr_u enc_j(input int word_target);
        instr_u w;
        w.j.opcode = JMP;
        w.j.target = word_target[25:0];
        return w;
    endfunction

    // runs one instruction on the model and reports the memory access it implies
    function automatic void execute_model(output bit mem_op, output bit store_op,
                                          output logic [`CPU_XLEN-1:0] maddr,
                                          output logic [`CPU_XLEN-1:0] sdata,
                                          output bit halt_op);
        instr_u               w;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
        logic [`CPU_XLEN-1:0] sext;
        logic [`CPU_XLEN-1:0] res;
        logic [`CPU_XLEN-1:0] next;
        bit                   wr;
        bit                   cmp;
        w        = m_mem[m_pc[9:2]];
        a        = m_regs[w.r.ra];
        b        = m_regs[w.r.rb];
        sext     = {{16{w.r.imm[15]}}, w.r.imm};
        next     = m_pc + 4;
        res      = '0;
        cmp      = (w.r.opcode == CMPEQ) || (w.r.opcode == CMPLT);
        mem_op   = (w.r.opcode == LOAD) || (w.r.opcode == STORE);
        store_op = (w.r.opcode == STORE);
        halt_op  = (w.r.opcode == HALT);
        maddr    = a + sext;
        sdata    = b;
        case (w.r.opcode)
            ADD, SUB, AND, OR, XOR, SHL, SHR, CMPEQ, CMPLT, LDI, LOAD: wr = 1'b1;
            default: wr = 1'b0;
        endcase
        case (w.r.opcode)
            ADD:   res = a + b;
            SUB:   res = a - b;
            AND:   res = a & b;
            OR:    res = a | b;
            XOR:   res = a ^ b;
            SHL:   res = a << b[4:0];
            SHR:   res = a >> b[4:0];
            CMPEQ: res = (a == b) ? 1 : 0;
            CMPLT: res = (a < b) ? 1 : 0;
            LDI:
            begin
                if (w.r.highlow)
                    res = {w.r.imm, m_regs[w.r.rd][15:0]};
                else
                    res = {16'h0, w.r.imm};
            end
            LOAD:  res = m_mem[maddr[9:2]];
            STORE: m_mem[maddr[9:2]] = b;
            BRF:
            begin
                if (m_flags[w.r.ra])
                    next = m_pc + 4 + (sext << 2);
            end
            JMP:   next = {4'h0, w.j.target, 2'b00};
            default: ;
        endcase
        if (wr)
        begin
            m_regs[w.r.rd]  = res;
            m_flags[w.r.rd] = cmp ? res[0] : (res == 0);
        end
        m_pc = next;
    endfunction

    task automatic load_program();
        instr_u p [$];
        p.push_back(enc_r(LDI, 1, 0, 0, 0, 'h5678));
        p.push_back(enc_r(LDI, 1, 0, 0, 1, 'h1234));
        p.push_back(enc_r(LDI, 2, 0, 0, 0, 'h00ff));
        p.push_back(enc_r(LDI, 2, 0, 0, 1, 'hf0f0));
        p.push_back(enc_r(ADD, 3, 1, 2, 0, 0));
        p.push_back(enc_r(SUB, 4, 1, 2, 0, 0));
        p.push_back(enc_r(AND, 5, 1, 2, 0, 0));
        p.push_back(enc_r(OR, 6, 1, 2, 0, 0));
        p.push_back(enc_r(XOR, 7, 1, 2, 0, 0));
        p.push_back(enc_r(LDI, 0, 0, 0, 0, 4));
        p.push_back(enc_r(SHL, 3, 1, 0, 0, 0));
        p.push_back(enc_r(SHR, 4, 2, 0, 0, 0));
        p.push_back(enc_r(LDI, 0, 0, 0, 0, 'h200));
        p.push_back(enc_r(STORE, 0, 0, 3, 0, 0));
        p.push_back(enc_r(STORE, 0, 0, 4, 0, 4));
        p.push_back(enc_r(LOAD, 5, 0, 0, 0, 4));
        p.push_back(enc_r(CMPEQ, 6, 5, 4, 0, 0));
        // taken on a true compare
        p.push_back(enc_r(BRF, 0, 6, 0, 0, 1));
        p.push_back(enc_r(LDI, 7, 0, 0, 0, 'hdead));
        p.push_back(enc_r(CMPLT, 6, 2, 1, 0, 0));
        p.push_back(enc_r(BRF, 0, 6, 0, 0, 2));
        p.push_back(enc_r(SUB, 7, 1, 1, 0, 0));
        // taken on a zero result
        p.push_back(enc_r(BRF, 0, 7, 0, 0, 1));
        p.push_back(enc_r(LDI, 4, 0, 0, 0, 'h0bad));
        p.push_back(enc_j(27));
        p.push_back(enc_r(LDI, 3, 0, 0, 0, 'h1111));
        p.push_back(enc_r(LDI, 3, 0, 0, 0, 'h2222));
        p.push_back(enc_r(CMPLT, 6, 1, 2, 0, 0));
        p.push_back(enc_r(LDI, 0, 0, 0, 0, RESULT_BASE));
        for (int i = 0; i < `CPU_NREGS; i++)
        begin
            p.push_back(enc_r(STORE, 0, 0, i, 0, 4 * i));
        end
        p.push_back(enc_r(HALT, 0, 0, 0, 0, 0));
        foreach (p[i])
        begin
            memory.mem[i] = p[i];
        end
    endtask

    task automatic wait_accept();
        do @(posedge clock);
        while (!(mem_req_valid && mem_req_ready));
    endtask

    task automatic wait_response();
        do @(posedge clock);
        while (!mem_rsp_valid);
    endtask

    // follows the bus and checks every request against the model
    task automatic run_program();
        bit                   mem_op;
        bit                   store_op;
        bit                   halt_op;
        logic [`CPU_XLEN-1:0] maddr;
        logic [`CPU_XLEN-1:0] sdata;
        int                   n;
        halt_op = 0;
        n       = 0;
        while (!halt_op)
        begin
            wait_accept();
            if (mem_write)
                report_fault($sformatf("fetch %0d was sent as a write", n));
            check_addr($sformatf("fetch %0d address", n), m_pc, mem_addr);
            wait_response();
            check_instr($sformatf("fetch %0d word", n), m_mem[m_pc[9:2]], mem_rdata);
            execute_model(mem_op, store_op, maddr, sdata, halt_op);
            if (mem_op)
            begin
                wait_accept();
                if (mem_write !== store_op)
                    report_fault($sformatf("instruction %0d has the wrong access kind", n));
                check_addr($sformatf("instruction %0d data address", n), maddr, mem_addr);
                if (store_op)
                    check_data($sformatf("instruction %0d store data", n), sdata, mem_wdata);
                wait_response();
            end
            n++;
        end
    endtask

    task automatic check_quiet_after_halt();
        do @(posedge clock);
        while (!halted);
        repeat (50)
        begin
            @(posedge clock);
            if (mem_req_valid)
                report_fault("request raised after halt");
        end
    endtask

    // request fields must not move while ready is low
    always @(posedge clock)
    begin
        if (!rst_n)
            held = 1'b0;
        else
        begin
            if (held && (!mem_req_valid || mem_addr !== h_addr || mem_write !== h_write
                         || (h_write && mem_wdata !== h_wdata)))
                report_fault("request dropped or changed while stalled");
            held    = mem_req_valid && !mem_req_ready;
            h_addr  = mem_addr;
            h_write = mem_write;
            h_wdata = mem_wdata;
        end
    end

    always @(posedge clock)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(32'hce14));
        clock          = 1'b0;
        rst_n          = 1'b0;
        mismatch_count = 0;
        fault_count    = 0;
        cycles         = 0;
        held           = 1'b0;
        #1;
        load_program();
        for (int i = 0; i < 256; i++)
        begin
            m_mem[i] = memory.mem[i];
        end
        for (int i = 0; i < `CPU_NREGS; i++)
        begin
            m_regs[i] = '0;
        end
        m_flags = '0;
        m_pc    = `CPU_RESET_PC;
        repeat (2) @(posedge clock);
        #10 rst_n = 1'b1;
        @(posedge clock);
        if (halted)
            report_fault("halted is high right after reset");
        run_program();
        check_quiet_after_halt();
        for (int i = 0; i < `CPU_NREGS; i++)
        begin
            check_data($sformatf("result word %0d", i), m_mem[RESULT_BASE / 4 + i],
                       memory.mem[RESULT_BASE / 4 + i]);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: test/tb_memory.sv
`include "cpu_defs.svh"

module tb_memory (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic [`CPU_XLEN-1:0] addr,
    input  logic                 write,
    input  logic [`CPU_XLEN-1:0] wdata,
    output logic                 rsp_valid,
    output logic [`CPU_XLEN-1:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 256;

    logic [`CPU_XLEN-1:0] mem [WORDS];
    logic [`CPU_XLEN-1:0] rsp_word;
    logic                 busy;
    int                   wait_cnt;
    int                   stall_cnt;

    // fill pattern mixes every address bit
    initial
    begin
        for (int i = 0; i < WORDS; i++)
        begin
            mem[i] = (i * 32'h0100_0193) ^ 32'h5a3c_96e1;
        end
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rdata     = '0;
        busy      = 1'b0;
        wait_cnt  = 0;
        stall_cnt = 0;
    end

    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            busy      = 1'b0;
            stall_cnt = 0;
        end
        else
        begin
            // a response seen on this edge has been taken
            if (rsp_valid)
                busy = 1'b0;
            else if (busy && wait_cnt > 0)
                wait_cnt--;
            if (req_valid && req_ready)
            begin
                if (write)
                    mem[addr[9:2]] = wdata;
                rsp_word  = write ? '0 : mem[addr[9:2]];
                busy      = 1'b1;
                wait_cnt  = $urandom_range(2, 0);
                stall_cnt = $urandom_range(3, 0);
            end
        end
        #10;
        rsp_valid = busy && (wait_cnt == 0);
        rdata     = rsp_valid ? rsp_word : '0;
        req_ready = rst_n && (stall_cnt == 0);
        // the stall only runs down while the next request is waiting
        if (req_valid && stall_cnt > 0)
            stall_cnt--;
    end

endmodule
